/* rtl/snd_dma_pkg.sv */
// Shared widths, register offsets and data types of the DMA sound block, imported by each module
package snd_dma_pkg;

    // ==============================
    // Address and data types
    // ==============================
    localparam int unsigned snd_waddr_w = 21;   // Word address width

    typedef logic [snd_waddr_w-1:0] snd_waddr_t; // Byte address bits 21:1
    typedef logic [7:0]             snd_byte_t;

    // One register data byte, decoded as an address byte or as control bits
    typedef union packed {
        snd_byte_t addr_byte;
        struct packed {
            logic [5:0] unused;
            logic       rpt;       // Repeat frame
            logic       enable;    // Sound DMA running
        } ctrl;
    } snd_reg_data_u;

    // ==============================
    // Register window at FF8900
    // ==============================
    localparam logic [15:0] snd_reg_base = 16'hFF89;  // Page FF89

    // Word offsets, byte address bits 7:1
    localparam logic [6:0] snd_reg_off_ctrl    = 7'd0;
    localparam logic [6:0] snd_reg_off_start_h = 7'd1;
    localparam logic [6:0] snd_reg_off_start_m = 7'd2;
    localparam logic [6:0] snd_reg_off_start_l = 7'd3;
    localparam logic [6:0] snd_reg_off_cnt_h   = 7'd4;   // Counter is read only
    localparam logic [6:0] snd_reg_off_cnt_m   = 7'd5;
    localparam logic [6:0] snd_reg_off_cnt_l   = 7'd6;
    localparam logic [6:0] snd_reg_off_end_h   = 7'd7;
    localparam logic [6:0] snd_reg_off_end_m   = 7'd8;
    localparam logic [6:0] snd_reg_off_end_l   = 7'd9;   // Last word of the window

    localparam snd_byte_t snd_unmapped_read = 8'hFF;

    // ==============================
    // Address FIFO
    // ==============================
    localparam int unsigned snd_fifo_depth = 4;   // Word addresses in flight

endpackage

/* rtl/snd_dma_regs.sv */
// CPU register window of the DMA sound block: control, frame start, frame end and counter view
`timescale 1ns/1ps

module snd_dma_regs (
    input  logic                    clk32,
    input  logic                    porb,
    // CPU side, low byte lane
    input  logic                    cpu_sel_i,
    input  logic                    cpu_we_i,
    input  logic [23:1]             cpu_addr_i,
    input  snd_dma_pkg::snd_byte_t  cpu_wdata_i,
    output snd_dma_pkg::snd_byte_t  cpu_rdata_o,
    output logic                    cpu_rvalid_o,
    // Address generator side
    input  snd_dma_pkg::snd_waddr_t cur_addr_i,
    input  logic                    snd_stop_i,
    output logic                    snd_enable_o,
    output logic                    snd_repeat_o,
    output snd_dma_pkg::snd_waddr_t frame_start_o,
    output snd_dma_pkg::snd_waddr_t frame_end_o
);

    import snd_dma_pkg::*;

    logic          enable_q;
    logic          repeat_q;
    snd_waddr_t    start_q;
    snd_waddr_t    end_q;
    snd_byte_t     rdata_q;
    logic          rvalid_q;

    logic [6:0]    word_off;
    logic          win_hit;
    logic          wr_hit;
    logic          rd_hit;
    snd_reg_data_u wr_u;
    snd_reg_data_u rd_u;

    // ==============================
    // Address decode
    // ==============================
    assign word_off = cpu_addr_i[7:1];
    assign win_hit  = (cpu_addr_i[23:8] == snd_reg_base) && (word_off <= snd_reg_off_end_l);
    assign wr_hit   = cpu_sel_i & cpu_we_i & win_hit;
    assign rd_hit   = cpu_sel_i & ~cpu_we_i & win_hit;
    assign wr_u     = cpu_wdata_i;

    // Control register, a CPU write beats a stop in the same cycle
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            enable_q <= 1'b0;
            repeat_q <= 1'b0;
        end else if (wr_hit && word_off == snd_reg_off_ctrl) begin
            enable_q <= wr_u.ctrl.enable;
            repeat_q <= wr_u.ctrl.rpt;
        end else if (snd_stop_i) begin
            enable_q <= 1'b0;            // Frame done without repeat
        end
    end

    // Frame start and end bytes
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            start_q <= '0;
            end_q   <= '0;
        end else if (wr_hit) begin
            case (word_off)
                snd_reg_off_start_h: start_q[20:15] <= wr_u.addr_byte[5:0];
                snd_reg_off_start_m: start_q[14:7]  <= wr_u.addr_byte;
                snd_reg_off_start_l: start_q[6:0]   <= wr_u.addr_byte[7:1];
                snd_reg_off_end_h:   end_q[20:15]   <= wr_u.addr_byte[5:0];
                snd_reg_off_end_m:   end_q[14:7]    <= wr_u.addr_byte;
                snd_reg_off_end_l:   end_q[6:0]     <= wr_u.addr_byte[7:1];
                default: ;                      // Control and counter
            endcase
        end
    end

    // ==============================
    // Read-back
    // ==============================
    always_comb begin
        rd_u = '0;
        case (word_off)
            snd_reg_off_ctrl: begin
                rd_u.ctrl.rpt    = repeat_q;
                rd_u.ctrl.enable = enable_q;
            end
            snd_reg_off_start_h: rd_u.addr_byte = {2'b00, start_q[20:15]};
            snd_reg_off_start_m: rd_u.addr_byte = start_q[14:7];
            snd_reg_off_start_l: rd_u.addr_byte = {start_q[6:0], 1'b0};
            snd_reg_off_cnt_h:   rd_u.addr_byte = {2'b00, cur_addr_i[20:15]};
            snd_reg_off_cnt_m:   rd_u.addr_byte = cur_addr_i[14:7];
            snd_reg_off_cnt_l:   rd_u.addr_byte = {cur_addr_i[6:0], 1'b0};
            snd_reg_off_end_h:   rd_u.addr_byte = {2'b00, end_q[20:15]};
            snd_reg_off_end_m:   rd_u.addr_byte = end_q[14:7];
            snd_reg_off_end_l:   rd_u.addr_byte = {end_q[6:0], 1'b0};
            default:             rd_u.addr_byte = snd_unmapped_read;
        endcase
    end

    // Read data one cycle after the strobe
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            rvalid_q <= 1'b0;
            rdata_q  <= '0;
        end else begin
            rvalid_q <= rd_hit;
            if (rd_hit) begin
                rdata_q <= rd_u.addr_byte;
            end
        end
    end

    assign cpu_rdata_o   = rdata_q;
    assign cpu_rvalid_o  = rvalid_q;
    assign snd_enable_o  = enable_q;
    assign snd_repeat_o  = repeat_q;
    assign frame_start_o = start_q;
    assign frame_end_o   = end_q;

endmodule

/* rtl/snd_addr_gen.sv */
// Sound frame address generator: steps through each frame on sample requests, raises frame end
`timescale 1ns/1ps

module snd_addr_gen (
    input  logic                    clk32,
    input  logic                    porb,
    input  logic                    snd_enable_i,
    input  logic                    snd_repeat_i,
    input  snd_dma_pkg::snd_waddr_t frame_start_i,
    input  snd_dma_pkg::snd_waddr_t frame_end_i,
    input  logic                    sreq_i,          // Sample request from the shifter
    input  logic                    gen_ready_i,
    output logic                    gen_valid_o,
    output snd_dma_pkg::snd_waddr_t gen_addr_o,
    output snd_dma_pkg::snd_waddr_t cur_addr_o,
    output logic                    snd_stop_o,
    output logic                    sint_o           // Frame end interrupt
);

    import snd_dma_pkg::*;

    logic       running_q;
    logic       pending_q;
    snd_waddr_t start_w_q;       // Working copy of frame start
    snd_waddr_t end_w_q;         // Working copy of frame end
    snd_waddr_t off_q;           // Words done in this frame

    snd_waddr_t cur_addr;
    snd_waddr_t next_addr;
    logic       xfer;
    logic       frame_last;
    logic       frame_load;

    assign cur_addr   = start_w_q + off_q;
    assign next_addr  = cur_addr + 1'b1;
    assign xfer       = gen_valid_o & gen_ready_i;
    assign frame_last = xfer & (next_addr == end_w_q);
    assign frame_load = snd_enable_i & ~running_q;   // Enable edge or restart after stop

    // ==============================
    // Frame sequencing
    // ==============================
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            running_q <= 1'b0;
        end else if (!snd_enable_i || snd_stop_o) begin
            running_q <= 1'b0;
        end else if (frame_load) begin
            running_q <= 1'b1;
        end
    end

    // New frame picks up the current register values
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            start_w_q <= '0;
            end_w_q   <= '0;
            off_q     <= '0;
        end else if (frame_load || frame_last) begin
            start_w_q <= frame_start_i;
            end_w_q   <= frame_end_i;
            off_q     <= '0;
        end else if (xfer) begin
            off_q <= off_q + 1'b1;
        end
    end

    // Pending request, a second one before the transfer merges
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            pending_q <= 1'b0;
        end else if (!snd_enable_i) begin
            pending_q <= 1'b0;
        end else if (sreq_i) begin
            pending_q <= 1'b1;
        end else if (xfer) begin
            pending_q <= 1'b0;
        end
    end

    assign gen_valid_o = running_q & pending_q;
    assign gen_addr_o  = cur_addr;
    assign cur_addr_o  = cur_addr;
    assign sint_o      = frame_last;
    assign snd_stop_o  = frame_last & ~snd_repeat_i;   // Single shot ends here

endmodule

/* rtl/snd_addr_fifo.sv */
// Small valid/ready FIFO holding sound word addresses between the generator and the fetch unit
`timescale 1ns/1ps

module snd_addr_fifo (
    input  logic                    clk32,
    input  logic                    porb,
    input  logic                    in_valid_i,
    input  snd_dma_pkg::snd_waddr_t in_addr_i,
    output logic                    in_ready_o,
    output logic                    out_valid_o,
    output snd_dma_pkg::snd_waddr_t out_addr_o,
    input  logic                    out_ready_i
);

    import snd_dma_pkg::*;

    snd_waddr_t                          mem [snd_fifo_depth];
    logic [$clog2(snd_fifo_depth)-1:0]   wr_ptr_q;
    logic [$clog2(snd_fifo_depth)-1:0]   rd_ptr_q;
    logic [$clog2(snd_fifo_depth+1)-1:0] count_q;
    logic                                push;
    logic                                pop;

    assign in_ready_o  = (count_q != snd_fifo_depth);   // Not full
    assign out_valid_o = (count_q != 0);
    assign out_addr_o  = mem[rd_ptr_q];
    assign push        = in_valid_i & in_ready_o;
    assign pop         = out_valid_o & out_ready_i;

    always_ff @(posedge clk32) begin
        if (push) begin
            mem[wr_ptr_q] <= in_addr_i;
        end
    end

    // Pointers wrap at the depth
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == snd_fifo_depth - 1) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == snd_fifo_depth - 1) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

/* rtl/snd_fetch.sv */
// Sound fetch unit: one memory read at a time per queued address, word handed to the shifter
`timescale 1ns/1ps

module snd_fetch (
    input  logic                    clk32,
    input  logic                    porb,
    input  logic                    q_valid_i,
    input  snd_dma_pkg::snd_waddr_t q_addr_i,
    output logic                    q_ready_o,
    output logic                    mem_valid_o,
    output snd_dma_pkg::snd_waddr_t mem_addr_o,
    input  logic                    mem_ready_i,
    input  logic [15:0]             mem_rdata_i,
    output logic [15:0]             sample_o,
    output logic                    sample_valid_o
);

    import snd_dma_pkg::*;

    logic        busy_q;         // Low idle, high requesting
    snd_waddr_t  addr_q;
    logic [15:0] sample_q;
    logic        sample_valid_q;

    assign q_ready_o   = ~busy_q;
    assign mem_valid_o = busy_q;
    assign mem_addr_o  = addr_q;

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            busy_q         <= 1'b0;
            addr_q         <= '0;
            sample_q       <= '0;
            sample_valid_q <= 1'b0;
        end else begin
            sample_valid_q <= 1'b0;
            if (!busy_q && q_valid_i) begin
                addr_q <= q_addr_i;         // Held until the memory takes it
                busy_q <= 1'b1;
            end else if (busy_q && mem_ready_i) begin
                sample_q       <= mem_rdata_i;
                sample_valid_q <= 1'b1;
                busy_q         <= 1'b0;
            end
        end
    end

    assign sample_o       = sample_q;
    assign sample_valid_o = sample_valid_q;

endmodule

/* rtl/snd_dma_top.sv */
// Top level of the DMA sound address path: registers, generator, address FIFO and fetch unit
`timescale 1ns/1ps

module snd_dma_top (
    input  logic                    clk32,
    input  logic                    porb,
    // CPU register bus
    input  logic                    cpu_sel_i,
    input  logic                    cpu_we_i,
    input  logic [23:1]             cpu_addr_i,
    input  snd_dma_pkg::snd_byte_t  cpu_wdata_i,
    output snd_dma_pkg::snd_byte_t  cpu_rdata_o,
    output logic                    cpu_rvalid_o,
    // Shifter side
    input  logic                    sreq_i,
    output logic                    sint_o,
    // Memory port
    output logic                    mem_valid_o,
    output snd_dma_pkg::snd_waddr_t mem_addr_o,
    input  logic                    mem_ready_i,
    input  logic [15:0]             mem_rdata_i,
    output logic [15:0]             sample_o,
    output logic                    sample_valid_o
);

    import snd_dma_pkg::*;

    logic       snd_enable;
    logic       snd_repeat;
    snd_waddr_t frame_start;
    snd_waddr_t frame_end;
    snd_waddr_t cur_addr;
    logic       snd_stop;
    logic       gen_valid;
    logic       gen_ready;
    snd_waddr_t gen_addr;
    logic       q_valid;
    logic       q_ready;
    snd_waddr_t q_addr;

    snd_dma_regs u_regs (
        .clk32        (clk32),
        .porb         (porb),
        .cpu_sel_i    (cpu_sel_i),
        .cpu_we_i     (cpu_we_i),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_wdata_i  (cpu_wdata_i),
        .cpu_rdata_o  (cpu_rdata_o),
        .cpu_rvalid_o (cpu_rvalid_o),
        .cur_addr_i   (cur_addr),
        .snd_stop_i   (snd_stop),
        .snd_enable_o (snd_enable),
        .snd_repeat_o (snd_repeat),
        .frame_start_o(frame_start),
        .frame_end_o  (frame_end)
    );

    snd_addr_gen u_gen (
        .clk32        (clk32),
        .porb         (porb),
        .snd_enable_i (snd_enable),
        .snd_repeat_i (snd_repeat),
        .frame_start_i(frame_start),
        .frame_end_i  (frame_end),
        .sreq_i       (sreq_i),
        .gen_ready_i  (gen_ready),
        .gen_valid_o  (gen_valid),
        .gen_addr_o   (gen_addr),
        .cur_addr_o   (cur_addr),
        .snd_stop_o   (snd_stop),
        .sint_o       (sint_o)
    );

    snd_addr_fifo u_fifo (
        .clk32      (clk32),
        .porb       (porb),
        .in_valid_i (gen_valid),
        .in_addr_i  (gen_addr),
        .in_ready_o (gen_ready),
        .out_valid_o(q_valid),
        .out_addr_o (q_addr),
        .out_ready_i(q_ready)
    );

    snd_fetch u_fetch (
        .clk32         (clk32),
        .porb          (porb),
        .q_valid_i     (q_valid),
        .q_addr_i      (q_addr),
        .q_ready_o     (q_ready),
        .mem_valid_o   (mem_valid_o),
        .mem_addr_o    (mem_addr_o),
        .mem_ready_i   (mem_ready_i),
        .mem_rdata_i   (mem_rdata_i),
        .sample_o      (sample_o),
        .sample_valid_o(sample_valid_o)
    );

endmodule

/* tests/snd_dma_assertions.sv */
// Protocol checks on the DMA sound top level, bound into it from this file
`timescale 1ns/1ps

module snd_dma_assertions (
    input logic                    clk32,
    input logic                    porb,
    input logic                    mem_valid_o,
    input logic                    mem_ready_i,
    input snd_dma_pkg::snd_waddr_t mem_addr_o,
    input logic                    sint_o,
    input logic                    sample_valid_o,
    input logic                    cpu_rvalid_o
);

    // Request held with a stable address until the memory takes it
    mem_hold: assert property (@(posedge clk32) disable iff (!porb)
        mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_addr_o))
        else $error("mem_addr_o changed or mem_valid_o dropped before mem_ready_i");

    sint_pulse: assert property (@(posedge clk32) disable iff (!porb) sint_o |=> !sint_o)
        else $error("sint_o high for more than one cycle");

    sample_pulse: assert property (@(posedge clk32) disable iff (!porb)
        sample_valid_o |=> !sample_valid_o)
        else $error("sample_valid_o high for more than one cycle");

    // Quiet outputs while porb is low
    reset_quiet: assert property (@(posedge clk32)
        !porb |-> !(mem_valid_o || sint_o || sample_valid_o || cpu_rvalid_o))
        else $error("Control output high during reset");

endmodule

bind snd_dma_top snd_dma_assertions dut_checks (
    .clk32         (clk32),
    .porb          (porb),
    .mem_valid_o   (mem_valid_o),
    .mem_ready_i   (mem_ready_i),
    .mem_addr_o    (mem_addr_o),
    .sint_o        (sint_o),
    .sample_valid_o(sample_valid_o),
    .cpu_rvalid_o  (cpu_rvalid_o)
);

/* tests/tb_snd_dma.sv */
// Testbench for the DMA sound block: random frames checked against a reference model of the path
`timescale 1ns/1ps

module tb_snd_dma;

    import snd_dma_pkg::*;

    localparam int n_single     = 6;                    // Random single shot frames
    localparam int n_frames     = n_single + 3;         // Plus the repeated frames
    localparam int max_words    = 12;
    localparam int max_stall    = 32;
    localparam int limit_cycles = n_frames * max_words * max_stall * 4;

    logic        clk32;
    logic        porb;
    logic        cpu_sel_i;
    logic        cpu_we_i;
    logic [23:1] cpu_addr_i;
    snd_byte_t   cpu_wdata_i;
    snd_byte_t   cpu_rdata_o;
    logic        cpu_rvalid_o;
    logic        sreq_i;
    logic        sint_o;
    logic        mem_valid_o;
    snd_waddr_t  mem_addr_o;
    logic        mem_ready_i;
    logic [15:0] mem_rdata_i;
    logic [15:0] sample_o;
    logic        sample_valid_o;

    integer      seed;
    integer      mem_seed;                              // Memory model stream
    integer      mem_rnd;
    int          rnd_word;
    int          stall_pct;
    logic [15:0] mem_salt;
    snd_waddr_t  mon_addr;
    snd_waddr_t  exp_addr[$];                           // Model of the address sequence
    logic [15:0] exp_sample[$];
    int          samples_seen;
    int          sint_seen;
    int          sint_exp;
    int          cycles;
    int          addr_errs, byte_errs, sample_errs, other_errs, total_errs;

    snd_dma_top dut0 (
        .clk32         (clk32),
        .porb          (porb),
        .cpu_sel_i     (cpu_sel_i),
        .cpu_we_i      (cpu_we_i),
        .cpu_addr_i    (cpu_addr_i),
        .cpu_wdata_i   (cpu_wdata_i),
        .cpu_rdata_o   (cpu_rdata_o),
        .cpu_rvalid_o  (cpu_rvalid_o),
        .sreq_i        (sreq_i),
        .sint_o        (sint_o),
        .mem_valid_o   (mem_valid_o),
        .mem_addr_o    (mem_addr_o),
        .mem_ready_i   (mem_ready_i),
        .mem_rdata_i   (mem_rdata_i),
        .sample_o      (sample_o),
        .sample_valid_o(sample_valid_o)
    );

    initial begin
        clk32 = 1'b0;
        forever #4 clk32 = ~clk32;
    end

    function automatic int rand_range(input int n);
        rand_range = $unsigned($random(seed)) % n;
    endfunction

    // Memory contents, every address bit takes part
    function automatic logic [15:0] mem_word(input snd_waddr_t a);
        mem_word = (a[15:0] * 16'h9E37) ^ {a[20:16], a[20:16], a[20:15]} ^ mem_salt;
    endfunction

    function automatic logic [23:1] reg_addr(input logic [6:0] off);
        reg_addr = {snd_reg_base, off};
    endfunction

    // ==============================
    // Checks
    // ==============================
    task automatic compare_addr(input string name, input snd_waddr_t exp, input snd_waddr_t act);
        if (act !== exp) begin
            addr_errs++;
            $display("** Error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic compare_byte(input string name, input snd_byte_t exp, input snd_byte_t act);
        if (act !== exp) begin
            byte_errs++;
            $display("** Error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic compare_sample(input string name, input logic [15:0] exp,
                                  input logic [15:0] act);
        if (act !== exp) begin
            sample_errs++;
            $display("** Error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic note_failure(input string msg);
        other_errs++;
        $display("%s", msg);
    endtask

    // ==============================
    // CPU bus
    // ==============================
    task automatic cpu_write(input logic [23:1] addr, input snd_byte_t data);
        @(negedge clk32);
        cpu_sel_i   = 1'b1;
        cpu_we_i    = 1'b1;
        cpu_addr_i  = addr;
        cpu_wdata_i = data;
        @(negedge clk32);
        cpu_sel_i = 1'b0;
        cpu_we_i  = 1'b0;
    endtask

    task automatic cpu_read(input logic [23:1] addr, input logic hit, output snd_byte_t data);
        @(negedge clk32);
        cpu_sel_i  = 1'b1;
        cpu_we_i   = 1'b0;
        cpu_addr_i = addr;
        @(negedge clk32);
        cpu_sel_i = 1'b0;
        data      = cpu_rdata_o;
        if (cpu_rvalid_o !== hit) begin
            note_failure($sformatf("Read of byte address %h did %sgive cpu_rvalid_o a cycle later",
                                   {addr, 1'b1}, hit ? "not " : ""));
        end
    endtask

    task automatic write_frame(input snd_waddr_t s, input snd_waddr_t e);
        cpu_write(reg_addr(snd_reg_off_start_h), {2'b00, s[20:15]});
        cpu_write(reg_addr(snd_reg_off_start_m), s[14:7]);
        cpu_write(reg_addr(snd_reg_off_start_l), {s[6:0], 1'b0});
        cpu_write(reg_addr(snd_reg_off_end_h), {2'b00, e[20:15]});
        cpu_write(reg_addr(snd_reg_off_end_m), e[14:7]);
        cpu_write(reg_addr(snd_reg_off_end_l), {e[6:0], 1'b0});
    endtask

    task automatic check_counter(input snd_waddr_t a);
        snd_byte_t r;
        cpu_read(reg_addr(snd_reg_off_cnt_h), 1'b1, r);
        compare_byte("cpu_rdata_o counter high", {2'b00, a[20:15]}, r);
        cpu_read(reg_addr(snd_reg_off_cnt_m), 1'b1, r);
        compare_byte("cpu_rdata_o counter middle", a[14:7], r);
        cpu_read(reg_addr(snd_reg_off_cnt_l), 1'b1, r);
        compare_byte("cpu_rdata_o counter low", {a[6:0], 1'b0}, r);
    endtask

    // ==============================
    // Test sequences
    // ==============================
    task automatic test_reg_readback();
        snd_reg_data_u w;
        snd_reg_data_u e;
        snd_byte_t     r;
        snd_byte_t     hi_exp;
        logic [6:0]    off;
        int            rnd;
        hi_exp = '0;
        for (int i = 1; i <= 9; i++) begin
            off = i[6:0];
            if (off == snd_reg_off_cnt_h || off == snd_reg_off_cnt_m || off == snd_reg_off_cnt_l)
                continue;
            rnd         = rand_range(256);
            w.addr_byte = rnd[7:0];
            e           = w;
            if (off == snd_reg_off_start_h || off == snd_reg_off_end_h) e.addr_byte[7:6] = 2'b00;
            if (off == snd_reg_off_start_l || off == snd_reg_off_end_l) e.addr_byte[0] = 1'b0;
            if (off == snd_reg_off_start_h) hi_exp = e.addr_byte;
            cpu_write(reg_addr(off), w.addr_byte);
            cpu_read(reg_addr(off), 1'b1, r);
            compare_byte($sformatf("cpu_rdata_o at offset %0d", off), e.addr_byte, r);
        end
        rnd           = rand_range(256);
        w.addr_byte   = rnd[7:0];
        w.ctrl.enable = 1'b0;                   // Keep the generator idle
        e             = '0;
        e.ctrl.rpt    = w.ctrl.rpt;
        cpu_write(reg_addr(snd_reg_off_ctrl), w.addr_byte);
        cpu_read(reg_addr(snd_reg_off_ctrl), 1'b1, r);
        compare_byte("cpu_rdata_o control", e.addr_byte, r);
        // Outside FF8900 to FF8913
        cpu_read(reg_addr(7'd10), 1'b0, r);
        cpu_read({16'hFF88, snd_reg_off_ctrl}, 1'b0, r);
        cpu_write({16'hFF8A, snd_reg_off_start_h}, ~hi_exp);
        cpu_read(reg_addr(snd_reg_off_start_h), 1'b1, r);
        compare_byte("cpu_rdata_o start high", hi_exp, r);
        cpu_write(reg_addr(snd_reg_off_ctrl), 8'h00);
    endtask

    // One frame without repeat, random requests and memory stalls
    task automatic run_single();
        snd_waddr_t    s;
        snd_waddr_t    a;
        snd_reg_data_u e;
        snd_byte_t     r;
        int            len;
        int            sreq_pct;
        int            target;
        int            rnd;
        @(posedge clk32);
        stall_pct = rand_range(4) * 25;
        len       = 1 + rand_range(max_words);
        sreq_pct  = 20 + rand_range(60);
        rnd       = rand_range(32'h100000);
        s         = {1'b0, rnd[19:0]};          // No wrap at the top of memory
        a         = s;
        repeat (len) begin
            exp_addr.push_back(a);
            a = a + 1'b1;
        end
        write_frame(s, a);
        cpu_write(reg_addr(snd_reg_off_ctrl), 8'h01);
        target = samples_seen + len;
        while (samples_seen < target) begin
            @(negedge clk32);
            sreq_i = (rand_range(100) < sreq_pct);
            @(posedge clk32);
        end
        @(negedge clk32);
        sreq_i = 1'b1;                          // Late requests find enable clear
        repeat (4) @(negedge clk32);
        sreq_i = 1'b0;
        repeat (8) @(negedge clk32);
        sint_exp++;
        e = '0;
        cpu_read(reg_addr(snd_reg_off_ctrl), 1'b1, r);
        compare_byte("cpu_rdata_o control after stop", e.addr_byte, r);
        check_counter(s);
    endtask

    // One request at a time, each waits for its sample
    task automatic serve_requests(input int n);
        int target;
        repeat (n) begin
            @(posedge clk32);
            target = samples_seen + 1;
            @(negedge clk32);
            sreq_i = 1'b1;
            @(negedge clk32);
            sreq_i = 1'b0;
            while (samples_seen < target) @(posedge clk32);
            repeat (rand_range(3)) @(negedge clk32);
        end
    endtask

    // Frame A with repeat, new frame B written part way through A
    task automatic run_repeat();
        snd_waddr_t sa;
        snd_waddr_t sb;
        snd_waddr_t a;
        int         len_a;
        int         len_b;
        int         k;
        int         rnd;
        @(posedge clk32);
        stall_pct = 50;
        len_a     = 2 + rand_range(max_words - 1);
        len_b     = 1 + rand_range(max_words);
        k         = 1 + rand_range(len_a - 1);
        rnd       = rand_range(32'h100000);
        sa        = {1'b0, rnd[19:0]};
        rnd       = rand_range(32'h100000);
        sb        = {1'b0, rnd[19:0]};
        a         = sa;
        repeat (len_a) begin
            exp_addr.push_back(a);
            a = a + 1'b1;
        end
        write_frame(sa, a);
        cpu_write(reg_addr(snd_reg_off_ctrl), 8'h03);
        serve_requests(k);
        repeat (2) begin
            a = sb;
            repeat (len_b) begin
                exp_addr.push_back(a);
                a = a + 1'b1;
            end
        end
        write_frame(sb, a);
        serve_requests(len_a - k + 2 * len_b);
        cpu_write(reg_addr(snd_reg_off_ctrl), 8'h00);
        sint_exp += 3;
    endtask

    // ==============================
    // Memory model and monitors
    // ==============================
    always @(negedge clk32) begin
        if (sample_valid_o) begin
            samples_seen++;
            if (exp_sample.size() == 0)
                note_failure("sample_valid_o pulsed with no sample outstanding");
            else
                compare_sample("sample_o", exp_sample.pop_front(), sample_o);
        end
        if (sint_o) sint_seen++;
        if (porb) begin
            mem_rnd     = $random(mem_seed);
            mem_ready_i = ($unsigned(mem_rnd) % 100) >= stall_pct;
            mem_rdata_i = mem_rnd[31:16];       // Junk unless a transfer
            if (mem_valid_o && mem_ready_i) begin
                if (exp_addr.size() == 0) begin
                    note_failure("Memory read issued with no address left in the model");
                end else begin
                    mon_addr = exp_addr.pop_front();
                    compare_addr("mem_addr_o", mon_addr, mem_addr_o);
                    mem_rdata_i = mem_word(mem_addr_o);
                    exp_sample.push_back(mem_word(mon_addr));
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < limit_cycles) begin
            @(posedge clk32);
            cycles++;
        end
        $display("Run timed out after %0d cycles", cycles);
        $display("test failed");
        $finish;
    end

    initial begin
        seed         = 32'h9dc6d378;
        mem_seed     = ~seed;
        porb         = 1'b0;
        cpu_sel_i    = 1'b0;
        cpu_we_i     = 1'b0;
        cpu_addr_i   = '0;
        cpu_wdata_i  = '0;
        sreq_i       = 1'b0;
        mem_ready_i  = 1'b0;
        mem_rdata_i  = '0;
        stall_pct    = 0;
        samples_seen = 0;
        sint_seen    = 0;
        sint_exp     = 0;
        addr_errs    = 0;
        byte_errs    = 0;
        sample_errs  = 0;
        other_errs   = 0;
        rnd_word     = $random(seed);
        mem_salt     = rnd_word[15:0];
        repeat (4) @(negedge clk32);
        porb = 1'b1;
        test_reg_readback();
        repeat (n_single) run_single();
        run_repeat();
        repeat (10) @(negedge clk32);
        if (exp_addr.size() != 0)
            note_failure($sformatf("%0d expected memory reads never issued", exp_addr.size()));
        if (exp_sample.size() != 0)
            note_failure($sformatf("%0d samples never delivered", exp_sample.size()));
        if (sint_seen != sint_exp) begin
            other_errs++;
            $display("** Error sint_o pulses: expected %h, got %h", sint_exp, sint_seen);
        end
        total_errs = addr_errs + byte_errs + sample_errs + other_errs;
        $display("Errors: address %0d, register %0d, sample %0d, other %0d",
                 addr_errs, byte_errs, sample_errs, other_errs);
        if (total_errs == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* files.f */
rtl/snd_dma_pkg.sv
rtl/snd_dma_regs.sv
rtl/snd_addr_gen.sv
rtl/snd_addr_fifo.sv
rtl/snd_fetch.sv
rtl/snd_dma_top.sv
tests/snd_dma_assertions.sv
tests/tb_snd_dma.sv
